// ==== list.f ====
+incdir+verilog
+incdir+bench
verilog/gb_pkg.sv
verilog/gb_memory_map.sv
verilog/gb_wram.sv
verilog/gb_timers.sv
verilog/gb_interrupts.sv
verilog/gb_bus_top.sv
bench/gb_bus_tb.sv

// ==== bench/gb_bus_tasks.svh ====
// Wishbone access tasks and the directed tests of the bus testbench.
// Included inside the testbench module and uses its signals directly.

// Expected ROM bytes
function automatic gb_pkg::data_t boot_byte(input gb_pkg::addr_t adr);
   return adr[7:0] ^ 8'h5A;
endfunction

function automatic gb_pkg::data_t cart_byte(input gb_pkg::addr_t adr);
   return adr[15:8] ^ adr[7:0];
endfunction

task automatic fail_run(input string msg);
   $display("%s", msg);
   $display("Test failed");
   $fatal(1, "stopping at first error");
endtask

task automatic compare_byte(input string what, input gb_pkg::data_t got,
                            input gb_pkg::data_t exp);
   assert (got === exp) else begin
      fail_run($sformatf("mismatch at %0t ns: %s read %h, expected %h",
                         $time, what, got, exp));
   end
endtask

task automatic expect_level(input string what, input logic got, input logic exp);
   assert (got === exp) else begin
      fail_run($sformatf("mismatch at %0t ns: %s is %b, expected %b",
                         $time, what, got, exp));
   end
endtask

// Request is held until ack, sampled on falling edges
task automatic wait_ack(input gb_pkg::addr_t adr);
   int cycles;
   cycles = 0;
   @(negedge clock);
   while (!wb_ack) begin
      cycles++;
      if (cycles > ACK_TIMEOUT)
         fail_run($sformatf("timeout at %0t ns: no wb_ack for address %h", $time, adr));
      @(negedge clock);
   end
endtask

task automatic bus_write(input gb_pkg::addr_t adr, input gb_pkg::data_t data);
   @(negedge clock);
   wb_cyc   = 1'b1;
   wb_stb   = 1'b1;
   wb_we    = 1'b1;
   wb_adr   = adr;
   wb_dat_i = data;
   wait_ack(adr);
   wb_cyc = 1'b0;
   wb_stb = 1'b0;
   wb_we  = 1'b0;
endtask

task automatic bus_read(input gb_pkg::addr_t adr, output gb_pkg::data_t data);
   @(negedge clock);
   wb_cyc = 1'b1;
   wb_stb = 1'b1;
   wb_we  = 1'b0;
   wb_adr = adr;
   wait_ack(adr);
   data   = wb_dat_o;
   wb_cyc = 1'b0;
   wb_stb = 1'b0;
endtask

task automatic read_expect(input string what, input gb_pkg::addr_t adr,
                           input gb_pkg::data_t exp);
   gb_pkg::data_t got;
   bus_read(adr, got);
   compare_byte($sformatf("%s at %h", what, adr), got, exp);
endtask

task automatic pulse_request(input int n);
   @(negedge clock);
   ext_int = 3'(1 << n);
   @(negedge clock);
   ext_int = 3'b000;
endtask

task automatic check_boot_overlay();
   int a;
   for (a = 0; a <= `GB_BOOT_END; a++)
      read_expect("boot ROM", 16'(a), boot_byte(16'(a)));
   read_expect("cartridge", 16'h0100, cart_byte(16'h0100));
   bus_write(`GB_MMIO_BOOT, 8'h01);
   read_expect("cartridge after unmap", 16'h0050, cart_byte(16'h0050));
   read_expect("boot register", `GB_MMIO_BOOT, 8'h01);
endtask

task automatic exercise_work_ram();
   gb_pkg::addr_t adr;
   gb_pkg::data_t data;
   int i;
   for (i = 0; i < 16; i++) begin
      adr  = `GB_WRAM_START + 16'($urandom % 32'h1E00);
      data = 8'($urandom);
      bus_write(adr, data);
      read_expect("work RAM", adr, data);
      read_expect("echo window", adr + 16'h2000, data);
   end
   // Echo write seen at the direct address
   adr  = `GB_ECHO_START + 16'($urandom % 32'h1E00);
   data = 8'($urandom);
   bus_write(adr, data);
   read_expect("work RAM after echo write", adr - 16'h2000, data);
endtask

task automatic probe_unmapped();
   read_expect("unmapped", 16'hFF80, 8'h00);
   read_expect("unmapped", 16'h9000, 8'h00);
   bus_write(16'h1234, 8'hAA);
   read_expect("cartridge after write", 16'h1234, cart_byte(16'h1234));
   bus_write(16'h0020, 8'h55);
   read_expect("cartridge after write", 16'h0020, cart_byte(16'h0020));
endtask

task automatic run_timer();
   gb_pkg::data_t value;
   int polls;
   bus_write(`GB_MMIO_TMA, 8'hF0);
   bus_write(`GB_MMIO_TIMA, 8'hFE);
   bus_write(`GB_MMIO_TAC, 8'h05);
   read_expect("TAC", `GB_MMIO_TAC, 8'h05);
   polls = 0;
   bus_read(`GB_MMIO_IF, value);
   while (!value[`GB_INT_TIMER]) begin
      polls++;
      if (polls > 100)
         fail_run("timer interrupt flag never set after TIMA overflow");
      bus_read(`GB_MMIO_IF, value);
   end
   bus_read(`GB_MMIO_TIMA, value);
   assert (value >= 8'hF0) else begin
      fail_run($sformatf("mismatch at %0t ns: TIMA read %h, expected at least f0",
                         $time, value));
   end
   // Stop the timer so later interrupt checks stay quiet
   bus_write(`GB_MMIO_TAC, 8'h00);
   bus_write(`GB_MMIO_IF, 8'h00);
   bus_write(`GB_MMIO_DIV, 8'h77);
   bus_read(`GB_MMIO_DIV, value);
   assert (value <= 8'h01) else begin
      fail_run($sformatf("mismatch at %0t ns: DIV read %h, expected 00 or 01",
                         $time, value));
   end
endtask

task automatic verify_interrupts();
   gb_pkg::data_t mask;
   int n;
   bus_write(`GB_MMIO_IE, 8'h00);
   for (n = 0; n < 3; n++) begin
      case (n)
         0:       mask = 8'h01 << `GB_INT_VBLANK;
         1:       mask = 8'h01 << `GB_INT_LCDC;
         default: mask = 8'h01 << `GB_INT_JOYPAD;
      endcase
      pulse_request(n);
      read_expect("IF after request", `GB_MMIO_IF, mask);
      expect_level("irq while disabled", irq, 1'b0);
      bus_write(`GB_MMIO_IE, mask);
      @(negedge clock);
      expect_level("irq when enabled", irq, 1'b1);
      bus_write(`GB_MMIO_IF, 8'h00);
      @(negedge clock);
      expect_level("irq after IF clear", irq, 1'b0);
      bus_write(`GB_MMIO_IE, 8'h00);
   end
   bus_write(`GB_MMIO_IE, 8'hFF);
   read_expect("IE top bits", `GB_MMIO_IE, 8'h1F);
   bus_write(`GB_MMIO_IF, 8'hFF);
   read_expect("IF top bits", `GB_MMIO_IF, 8'h1F);
   expect_level("irq with all flags", irq, 1'b1);
endtask

task automatic recheck_reset_state();
   // A request is held through reset, so the ack must stay low
   @(negedge clock);
   reset  = 1'b1;
   wb_cyc = 1'b1;
   wb_stb = 1'b1;
   wb_we  = 1'b0;
   wb_adr = `GB_MMIO_IF;
   repeat (2) begin
      @(negedge clock);
      expect_level("wb_ack during reset", wb_ack, 1'b0);
   end
   wb_cyc = 1'b0;
   wb_stb = 1'b0;
   reset  = 1'b0;
   expect_level("irq after reset", irq, 1'b0);
   read_expect("IF after reset", `GB_MMIO_IF, 8'h00);
   read_expect("IE after reset", `GB_MMIO_IE, 8'h00);
   read_expect("boot ROM after reset", 16'h0050, boot_byte(16'h0050));
   read_expect("boot register after reset", `GB_MMIO_BOOT, 8'h00);
endtask

// ==== bench/gb_bus_tb.sv ====
// Testbench for the console memory bus. Drives the Wishbone port,
// models the boot and cartridge ROM and runs the directed tests in
// order. Compile with list.f, top module gb_bus_tb.

`timescale 1ns/1ns
`include "gb_params.svh"

module gb_bus_tb;
   localparam int ACK_TIMEOUT = 16;

   logic          clock;
   logic          reset;
   logic          wb_cyc;
   logic          wb_stb;
   logic          wb_we;
   gb_pkg::addr_t wb_adr;
   gb_pkg::data_t wb_dat_i;
   gb_pkg::data_t wb_dat_o;
   logic          wb_ack;
   gb_pkg::addr_t rom_addr;
   logic          rom_boot;
   gb_pkg::data_t rom_data;
   logic [2:0]    ext_int;
   logic          irq;
   int            seed_value;

   gb_bus_top uut (
      .clock, .reset,
      .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_i, .wb_dat_o, .wb_ack,
      .rom_addr, .rom_boot, .rom_data,
      .ext_int, .irq
   );

   always #10 clock = ~clock;

   // ROM model, boot image while the overlay is mapped
   assign rom_data = rom_boot ? (rom_addr[7:0] ^ 8'h5A) : (rom_addr[15:8] ^ rom_addr[7:0]);

   `include "gb_bus_tasks.svh"

   initial begin
      clock      = 1'b0;
      reset      = 1'b1;
      wb_cyc     = 1'b0;
      wb_stb     = 1'b0;
      wb_we      = 1'b0;
      wb_adr     = 16'h0000;
      wb_dat_i   = 8'h00;
      ext_int    = 3'b000;
      seed_value = $urandom(43965);
      repeat (2) @(negedge clock);
      reset = 1'b0;

      check_boot_overlay();
      exercise_work_ram();
      probe_unmapped();
      run_timer();
      verify_interrupts();
      recheck_reset_state();

      $display("Test completed successfully");
      $finish;
   end

endmodule

// ==== verilog/gb_bus_top.sv ====
// Top level of the console memory bus. A Wishbone slave port reaches
// the work RAM, timers, interrupt registers and the external ROM port.
// irq goes to the CPU, ext_int carries video and joypad requests.

`timescale 1ns/1ns

module gb_bus_top (
   input  logic             clock,
   input  logic             reset,
   input  logic             wb_cyc,
   input  logic             wb_stb,
   input  logic             wb_we,
   input  gb_pkg::addr_t    wb_adr,
   input  gb_pkg::data_t    wb_dat_i,
   output gb_pkg::data_t    wb_dat_o,
   output logic             wb_ack,
   output gb_pkg::addr_t    rom_addr,
   output logic             rom_boot,
   input  gb_pkg::data_t    rom_data,
   input  logic [2:0]       ext_int,
   output logic             irq
);
   gb_pkg::wram_addr_t ram_addr;
   logic               ram_we;
   gb_pkg::data_t      ram_q;
   logic [1:0]         timer_sel;
   logic               timer_we;
   gb_pkg::data_t      timer_q;
   logic               timer_irq;
   logic               if_we;
   logic               ie_we;
   gb_pkg::int_vec_t   if_q;
   gb_pkg::int_vec_t   ie_q;
   gb_pkg::data_t      wr_data;

   gb_memory_map map (
      .clock, .reset,
      .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_i, .wb_dat_o, .wb_ack,
      .rom_addr, .rom_boot, .rom_data,
      .ram_addr, .ram_we, .ram_q,
      .timer_sel, .timer_we, .timer_q,
      .if_we, .ie_we, .if_q, .ie_q,
      .wr_data
   );

   gb_wram wram (
      .clock, .ram_we, .ram_addr, .wr_data, .ram_q
   );

   gb_timers timers (
      .clock, .reset, .timer_sel, .timer_we, .wr_data, .timer_q, .timer_irq
   );

   gb_interrupts ints (
      .clock, .reset, .timer_irq, .ext_int,
      .if_we, .ie_we, .wr_data, .if_q, .ie_q, .irq
   );

endmodule

// ==== verilog/gb_interrupts.sv ====
// Interrupt flag and enable registers. Request pulses from the timer
// and the external sources set IF bits; irq is raised while any
// flagged source is also enabled.

`timescale 1ns/1ns
`include "gb_params.svh"

module gb_interrupts (
   input  logic             clock,
   input  logic             reset,
   input  logic             timer_irq,
   input  logic [2:0]       ext_int,
   input  logic             if_we,
   input  logic             ie_we,
   input  gb_pkg::data_t    wr_data,
   output gb_pkg::int_vec_t if_q,
   output gb_pkg::int_vec_t ie_q,
   output logic             irq
);
   gb_pkg::int_vec_t req;
   gb_pkg::int_vec_t if_base;

   always_comb begin
      req = '0;
      req[`GB_INT_VBLANK] = ext_int[0];
      req[`GB_INT_LCDC]   = ext_int[1];
      req[`GB_INT_TIMER]  = timer_irq;
      // No serial port behind this bus
      req[`GB_INT_SERIAL] = 1'b0;
      req[`GB_INT_JOYPAD] = ext_int[2];
   end

   // Requests in the same cycle still land on top of a CPU write
   assign if_base = if_we ? wr_data[4:0] : if_q;

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         if_q <= '0;
         ie_q <= '0;
      end else begin
         if_q <= if_base | req;
         if (ie_we)
            ie_q <= wr_data[4:0];
      end
   end

   assign irq = |(if_q & ie_q);

endmodule

// ==== verilog/gb_timers.sv ====
// DIV, TIMA, TMA and TAC timer registers. A free-running 16-bit divider
// feeds TIMA through the tap that TAC selects; TIMA overflow reloads
// from TMA and pulses timer_irq to the interrupt unit.

`timescale 1ns/1ns
`include "gb_params.svh"

module gb_timers (
   input  logic          clock,
   input  logic          reset,
   input  logic [1:0]    timer_sel,
   input  logic          timer_we,
   input  gb_pkg::data_t wr_data,
   output gb_pkg::data_t timer_q,
   output logic          timer_irq
);
   localparam logic [15:0] tap_table = `GB_DIV_TAPS;

   logic [15:0]   div_cnt;
   gb_pkg::data_t tima;
   gb_pkg::data_t tma;
   logic [2:0]    tac;
   logic [3:0]    tap_sel;
   logic          tap_bit;
   logic          tap_prev;
   logic          tick;
   logic          div_write;
   logic          tima_write;
   logic          tma_write;
   logic          tac_write;

   assign div_write  = timer_we & (timer_sel == 2'd0);
   assign tima_write = timer_we & (timer_sel == 2'd1);
   assign tma_write  = timer_we & (timer_sel == 2'd2);
   assign tac_write  = timer_we & (timer_sel == 2'd3);

   // Falling edge of the selected divider bit
   assign tap_sel   = tap_table[{tac[1:0], 2'b00} +: 4];
   assign tap_bit   = div_cnt[tap_sel];
   assign tick      = tac[2] & tap_prev & ~tap_bit;

   // A CPU write to TIMA wins over the overflow
   assign timer_irq = tick & (tima == 8'hFF) & ~tima_write;

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         div_cnt  <= 16'h0000;
         tap_prev <= 1'b0;
      end else begin
         div_cnt  <= div_write ? 16'h0000 : div_cnt + 16'd1;
         tap_prev <= tap_bit;
      end
   end

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         tima <= 8'h00;
         tma  <= 8'h00;
         tac  <= 3'b000;
      end else begin
         if (tima_write)
            tima <= wr_data;
         else if (tick)
            tima <= (tima == 8'hFF) ? tma : tima + 8'd1;
         if (tma_write)
            tma <= wr_data;
         if (tac_write)
            tac <= wr_data[2:0];
      end
   end

   always_comb begin
      case (timer_sel)
         2'd0:    timer_q = div_cnt[15:8];
         2'd1:    timer_q = tima;
         2'd2:    timer_q = tma;
         default: timer_q = {5'b00000, tac};
      endcase
   end

endmodule

// ==== verilog/gb_wram.sv ====
// 8 KiB work RAM behind the bus decoder. The index already folds the
// echo window. Writes land on the clock edge, reads are combinational.

`timescale 1ns/1ns

module gb_wram (
   input  logic               clock,
   input  logic               ram_we,
   input  gb_pkg::wram_addr_t ram_addr,
   input  gb_pkg::data_t      wr_data,
   output gb_pkg::data_t      ram_q
);
   gb_pkg::data_t mem [0:8191];

   always_ff @(posedge clock) begin
      if (ram_we)
         mem[ram_addr] <= wr_data;
   end

   // Asynchronous read port
   assign ram_q = mem[ram_addr];

endmodule

// ==== verilog/gb_memory_map.sv ====
// Wishbone slave and address decoder of the console bus. Holds the
// boot-overlay register, issues one-cycle write strobes to the blocks
// behind it and registers the selected read byte with the acknowledge.

`timescale 1ns/1ns
`include "gb_params.svh"

module gb_memory_map (
   input  logic               clock,
   input  logic               reset,
   input  logic               wb_cyc,
   input  logic               wb_stb,
   input  logic               wb_we,
   input  gb_pkg::addr_t      wb_adr,
   input  gb_pkg::data_t      wb_dat_i,
   output gb_pkg::data_t      wb_dat_o,
   output logic               wb_ack,
   output gb_pkg::addr_t      rom_addr,
   output logic               rom_boot,
   input  gb_pkg::data_t      rom_data,
   output gb_pkg::wram_addr_t ram_addr,
   output logic               ram_we,
   input  gb_pkg::data_t      ram_q,
   output logic [1:0]         timer_sel,
   output logic               timer_we,
   input  gb_pkg::data_t      timer_q,
   output logic               if_we,
   output logic               ie_we,
   input  gb_pkg::int_vec_t   if_q,
   input  gb_pkg::int_vec_t   ie_q,
   output gb_pkg::data_t      wr_data
);
   gb_pkg::region_t region;
   gb_pkg::data_t   boot_reg;
   gb_pkg::data_t   rd_byte;
   logic            access;
   logic            wr_access;

   // New request seen, ack goes out on the next edge
   assign access    = wb_cyc & wb_stb & ~wb_ack;
   assign wr_access = access & wb_we;

   always_comb begin
      if (!boot_reg[0] && wb_adr <= `GB_BOOT_END)
         region = gb_pkg::REGION_BOOT;
      else if (wb_adr <= `GB_CART_END)
         region = gb_pkg::REGION_CART;
      else if (wb_adr >= `GB_WRAM_START && wb_adr <= `GB_WRAM_END)
         region = gb_pkg::REGION_WRAM;
      else if (wb_adr >= `GB_ECHO_START && wb_adr <= `GB_ECHO_END)
         region = gb_pkg::REGION_WRAM;
      else if (wb_adr >= `GB_MMIO_DIV && wb_adr <= `GB_MMIO_TAC)
         region = gb_pkg::REGION_TIMER;
      else if (wb_adr == `GB_MMIO_IF)
         region = gb_pkg::REGION_IF;
      else if (wb_adr == `GB_MMIO_IE)
         region = gb_pkg::REGION_IE;
      else if (wb_adr == `GB_MMIO_BOOT)
         region = gb_pkg::REGION_BOOTREG;
      else
         region = gb_pkg::REGION_NONE;
   end

   assign rom_addr = wb_adr;
   assign rom_boot = (region == gb_pkg::REGION_BOOT);

   // Both windows are 8 KiB aligned, so echo folds onto the same index
   assign ram_addr  = wb_adr[12:0];
   assign timer_sel = wb_adr[1:0];
   assign wr_data   = wb_dat_i;

   // ROM regions take no write strobe
   assign ram_we   = wr_access & (region == gb_pkg::REGION_WRAM);
   assign timer_we = wr_access & (region == gb_pkg::REGION_TIMER);
   assign if_we    = wr_access & (region == gb_pkg::REGION_IF);
   assign ie_we    = wr_access & (region == gb_pkg::REGION_IE);

   always_comb begin
      case (region)
         gb_pkg::REGION_BOOT,
         gb_pkg::REGION_CART:    rd_byte = rom_data;
         gb_pkg::REGION_WRAM:    rd_byte = ram_q;
         gb_pkg::REGION_TIMER:   rd_byte = timer_q;
         gb_pkg::REGION_IF:      rd_byte = {3'b000, if_q};
         gb_pkg::REGION_IE:      rd_byte = {3'b000, ie_q};
         gb_pkg::REGION_BOOTREG: rd_byte = boot_reg;
         default:                rd_byte = 8'h00;
      endcase
   end

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         wb_ack   <= 1'b0;
         wb_dat_o <= 8'h00;
         boot_reg <= 8'h00;
      end else begin
         wb_ack <= access;
         if (access && !wb_we)
            wb_dat_o <= rd_byte;
         // Bit 0 set unmaps the boot overlay
         if (wr_access && region == gb_pkg::REGION_BOOTREG)
            boot_reg <= wb_dat_i;
      end
   end

endmodule

// ==== verilog/gb_pkg.sv ====
// Shared types for the console bus: addresses, bytes, RAM index,
// interrupt vector and the decoded region of an access.
// Modules refer to these by scoped name.

package gb_pkg;

   typedef logic [15:0] addr_t;
   typedef logic [7:0]  data_t;
   typedef logic [12:0] wram_addr_t;

   // One bit per interrupt source
   typedef logic [4:0]  int_vec_t;

   typedef enum logic [2:0] {
      REGION_BOOT,
      REGION_CART,
      REGION_WRAM,
      REGION_TIMER,
      REGION_IF,
      REGION_IE,
      REGION_BOOTREG,
      REGION_NONE
   } region_t;

endpackage

// ==== verilog/gb_params.svh ====
// Address map and register constants for the console memory bus.
// Included by the RTL and the bench wherever an address, an interrupt
// bit or a timer tap is needed.

`ifndef GB_PARAMS_SVH
`define GB_PARAMS_SVH

// Boot overlay and cartridge ROM
`define GB_BOOT_END     16'h00FF
`define GB_CART_END     16'h7FFF

// Work RAM and its echo window
`define GB_WRAM_START   16'hC000
`define GB_WRAM_END     16'hDFFF
`define GB_ECHO_START   16'hE000
`define GB_ECHO_END     16'hFDFF

// Memory-mapped registers
`define GB_MMIO_DIV     16'hFF04
`define GB_MMIO_TIMA    16'hFF05
`define GB_MMIO_TMA     16'hFF06
`define GB_MMIO_TAC     16'hFF07
`define GB_MMIO_IF      16'hFF0F
`define GB_MMIO_BOOT    16'hFF50
`define GB_MMIO_IE      16'hFFFF

// Interrupt bit positions in IF and IE
`define GB_INT_VBLANK   0
`define GB_INT_LCDC     1
`define GB_INT_TIMER    2
`define GB_INT_SERIAL   3
`define GB_INT_JOYPAD   4

// Divider bit per TAC rate, 4 bits each, setting 3 in the top nibble
`define GB_DIV_TAPS     {4'd7, 4'd5, 4'd3, 4'd9}

`endif
